// ==== common/core_pkg.sv ====
// core package: stream widths, routing SIDs, settings addresses and shared enums
package core_pkg;

   ////////////////////////////////////////////////////////////
   // stream and routing
   ////////////////////////////////////////////////////////////
   localparam int DATA_W = 64;

   // masked destination SIDs
   localparam logic [7:0] SID_MASK       = 8'hf0;
   localparam logic [7:0] LOCAL_CTRL_SID = 8'h40;
   localparam logic [7:0] RADIO_CTRL_SID = 8'h10;

   ////////////////////////////////////////////////////////////
   // settings bus addresses
   ////////////////////////////////////////////////////////////
   localparam logic [7:0] SR_CORE_MISC     = 8'd16;
   localparam logic [7:0] SR_CORE_READBACK = 8'd32;
   localparam logic [7:0] SR_CORE_SYNC     = 8'd48;

   // compat word, readback slot 0
   localparam logic [31:0] COMPAT_SIGNATURE = 32'hace0ba5e;
   localparam logic [15:0] COMPAT_MAJOR     = 16'h000e;
   localparam logic [15:0] COMPAT_MINOR     = 16'h0000;

   ////////////////////////////////////////////////////////////
   // enums
   ////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      DEST_LOCAL,
      DEST_RADIO,
      DEST_DROP
   } sid_dest_e;

   typedef enum logic [2:0] {
      ST_HDR,
      ST_CMD,
      ST_DRAIN,
      ST_WRITE,
      ST_RESP_HDR,
      ST_RESP_DATA
   } ctrl_state_e;

   typedef enum logic [1:0] {
      PPS_GPSDO    = 2'd0,
      PPS_EXT      = 2'd1,
      PPS_INTERNAL = 2'd2,
      PPS_OFF      = 2'd3
   } pps_src_e;

   // indices 4..7 read back as zero
   typedef enum logic [2:0] {
      RB_COMPAT   = 3'd0,
      RB_MISC_IN  = 3'd1,
      RB_LOCK     = 3'd2,
      RB_SETTINGS = 3'd3
   } rb_sel_e;

endpackage

// ==== source/ctrl_demux.sv ====
// control demux: steers control packets by masked SID to local or radio port, or drops them
`timescale 1ns/1ns

module ctrl_demux
   import core_pkg::*;
(
   input  logic              i_bus_clk,
   input  logic              i_bus_rst,
   input  logic [DATA_W-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              o_tready,
   output logic [DATA_W-1:0] o_local_tdata,
   output logic              o_local_tlast,
   output logic              o_local_tvalid,
   input  logic              i_local_tready,
   output logic [DATA_W-1:0] o_radio_tdata,
   output logic              o_radio_tlast,
   output logic              o_radio_tvalid,
   input  logic              i_radio_tready
);

   logic      mid_pkt;
   sid_dest_e hdr_dest;
   sid_dest_e dest_q;
   sid_dest_e dest;

   // decode of the header beat
   always_comb begin
      if ((i_tdata[7:0] & SID_MASK) == LOCAL_CTRL_SID) begin
         hdr_dest = DEST_LOCAL;
      end else if ((i_tdata[7:0] & SID_MASK) == RADIO_CTRL_SID) begin
         hdr_dest = DEST_RADIO;
      end else begin
         hdr_dest = DEST_DROP;
      end
   end

   assign dest = mid_pkt ? dest_q : hdr_dest;

   // hold the destination until tlast
   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         mid_pkt <= 1'b0;
         dest_q  <= DEST_DROP;
      end else if (i_tvalid && o_tready) begin
         mid_pkt <= !i_tlast;
         if (!mid_pkt) begin
            dest_q <= hdr_dest;
         end
      end
   end

   assign o_local_tdata  = i_tdata;
   assign o_local_tlast  = i_tlast;
   assign o_local_tvalid = i_tvalid && (dest == DEST_LOCAL);
   assign o_radio_tdata  = i_tdata;
   assign o_radio_tlast  = i_tlast;
   assign o_radio_tvalid = i_tvalid && (dest == DEST_RADIO);

   // dropped packets are swallowed at full rate
   always_comb begin
      case (dest)
         DEST_LOCAL: o_tready = i_local_tready;
         DEST_RADIO: o_tready = i_radio_tready;
         default:    o_tready = 1'b1;
      endcase
   end

endmodule

// ==== source/resp_mux.sv ====
// response mux: packet-atomic round-robin merge of two response streams
`timescale 1ns/1ns

module resp_mux
   import core_pkg::*;
(
   input  logic              i_bus_clk,
   input  logic              i_bus_rst,
   input  logic [DATA_W-1:0] i_a_tdata,
   input  logic              i_a_tlast,
   input  logic              i_a_tvalid,
   output logic              o_a_tready,
   input  logic [DATA_W-1:0] i_b_tdata,
   input  logic              i_b_tlast,
   input  logic              i_b_tvalid,
   output logic              o_b_tready,
   output logic [DATA_W-1:0] o_tdata,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              i_tready
);

   // select 0 is input a, 1 is input b
   logic busy;
   logic grant;
   logic last_win;
   logic pick;
   logic sel;
   logic pkt_end;

   // alternate when both wait
   always_comb begin
      if (i_a_tvalid && i_b_tvalid) begin
         pick = ~last_win;
      end else begin
         pick = i_b_tvalid;
      end
   end

   assign sel = busy ? grant : pick;

   assign o_tdata    = sel ? i_b_tdata  : i_a_tdata;
   assign o_tlast    = sel ? i_b_tlast  : i_a_tlast;
   assign o_tvalid   = sel ? i_b_tvalid : i_a_tvalid;
   assign o_a_tready = i_tready && !sel;
   assign o_b_tready = i_tready && sel;
   assign pkt_end    = o_tvalid && i_tready && o_tlast;

   // lock the grant once a beat is offered, so the output stays stable
   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         busy     <= 1'b0;
         grant    <= 1'b0;
         last_win <= 1'b1;
      end else begin
         if (!busy) begin
            if (o_tvalid && !pkt_end) begin
               busy  <= 1'b1;
               grant <= sel;
            end
         end else if (pkt_end) begin
            busy <= 1'b0;
         end
         if (pkt_end) begin
            last_win <= sel;
         end
      end
   end

endmodule

// ==== ctrl_proc/ctrl_proc.sv ====
// control processor: parses command packets, strobes the settings bus, returns readback
`timescale 1ns/1ns

module ctrl_proc
   import core_pkg::*;
(
   input  logic              i_bus_clk,
   input  logic              i_bus_rst,
   input  logic [DATA_W-1:0] i_ctrl_tdata,
   input  logic              i_ctrl_tlast,
   input  logic              i_ctrl_tvalid,
   output logic              o_ctrl_tready,
   output logic [DATA_W-1:0] o_resp_tdata,
   output logic              o_resp_tlast,
   output logic              o_resp_tvalid,
   input  logic              i_resp_tready,
   output logic              o_set_stb,
   output logic [7:0]        o_set_addr,
   output logic [31:0]       o_set_data,
   input  logic [DATA_W-1:0] i_readback
);

   ctrl_state_e       state;
   logic [DATA_W-1:0] hdr_q;
   logic [DATA_W-1:0] cmd_q;
   logic [DATA_W-1:0] rb_q;
   logic              ctrl_beat;
   logic              resp_beat;

   assign ctrl_beat = i_ctrl_tvalid && o_ctrl_tready;
   assign resp_beat = o_resp_tvalid && i_resp_tready;

   ////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         state <= ST_HDR;
      end else begin
         case (state)
            // a lone header beat carries no command and is dropped
            ST_HDR: begin
               if (ctrl_beat && !i_ctrl_tlast) begin
                  state <= ST_CMD;
               end
            end
            ST_CMD: begin
               if (ctrl_beat) begin
                  state <= i_ctrl_tlast ? ST_WRITE : ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               if (ctrl_beat && i_ctrl_tlast) begin
                  state <= ST_WRITE;
               end
            end
            ST_WRITE: state <= ST_RESP_HDR;
            ST_RESP_HDR: begin
               if (resp_beat) begin
                  state <= ST_RESP_DATA;
               end
            end
            ST_RESP_DATA: begin
               if (resp_beat) begin
                  state <= ST_HDR;
               end
            end
            default: state <= ST_HDR;
         endcase
      end
   end

   // header, command and readback capture
   always_ff @(posedge i_bus_clk) begin
      if (state == ST_HDR && ctrl_beat) begin
         hdr_q <= i_ctrl_tdata;
      end
      if (state == ST_CMD && ctrl_beat) begin
         cmd_q <= i_ctrl_tdata;
      end
      // sampled after the write lands, frozen while the data beat waits
      if (state == ST_RESP_HDR) begin
         rb_q <= i_readback;
      end
   end

   assign o_ctrl_tready = (state == ST_HDR) || (state == ST_CMD) || (state == ST_DRAIN);

   assign o_set_stb  = (state == ST_WRITE);
   assign o_set_addr = cmd_q[39:32];
   assign o_set_data = cmd_q[31:0];

   ////////////////////////////////////////////////////////////
   // response, header with SIDs swapped then readback word
   ////////////////////////////////////////////////////////////
   assign o_resp_tvalid = (state == ST_RESP_HDR) || (state == ST_RESP_DATA);
   assign o_resp_tlast  = (state == ST_RESP_DATA);
   assign o_resp_tdata  = (state == ST_RESP_DATA) ? rb_q :
                          {hdr_q[DATA_W-1:16], hdr_q[7:0], hdr_q[15:8]};

endmodule

// ==== ctrl_proc/core_settings.sv ====
// core settings: misc, readback select and PPS source registers with readback mux
`timescale 1ns/1ns

module core_settings
   import core_pkg::*;
(
   input  logic              i_bus_clk,
   input  logic              i_bus_rst,
   input  logic              i_set_stb,
   input  logic [7:0]        i_set_addr,
   input  logic [31:0]       i_set_data,
   input  logic [1:0]        i_lock_signals,
   input  logic [31:0]       i_rb_misc,
   output logic [DATA_W-1:0] o_readback,
   output logic [31:0]       o_misc_outs,
   output pps_src_e          o_pps_src
);

   logic [31:0] misc_q;
   rb_sel_e     rb_sel;
   pps_src_e    pps_src;
   logic [1:0]  lock_meta;
   logic [1:0]  lock_sync;

   ////////////////////////////////////////////////////////////
   // setting registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         misc_q  <= '0;
         rb_sel  <= RB_COMPAT;
         pps_src <= PPS_GPSDO;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_CORE_MISC:     misc_q  <= i_set_data;
            SR_CORE_READBACK: rb_sel  <= rb_sel_e'(i_set_data[2:0]);
            SR_CORE_SYNC:     pps_src <= pps_src_e'(i_set_data[1:0]);
            default:          ;
         endcase
      end
   end

   // lock signals come from the front end, two stages
   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         lock_meta <= '0;
         lock_sync <= '0;
      end else begin
         lock_meta <= i_lock_signals;
         lock_sync <= lock_meta;
      end
   end

   ////////////////////////////////////////////////////////////
   // readback mux
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (rb_sel)
         RB_COMPAT:   o_readback = {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
         RB_MISC_IN:  o_readback = {32'h0, i_rb_misc};
         RB_LOCK:     o_readback = {62'h0, lock_sync};
         RB_SETTINGS: o_readback = {30'h0, pps_src, misc_q};
         default:     o_readback = '0;
      endcase
   end

   assign o_misc_outs = misc_q;
   assign o_pps_src   = pps_src;

endmodule

// ==== source/pps_select.sv ====
// PPS selector: internal PPS generator, input synchronizers and source mux
`timescale 1ns/1ns

module pps_select
   import core_pkg::*;
#(
   parameter int PPS_PERIOD = 100_000_000
) (
   input  logic     i_bus_clk,
   input  logic     i_bus_rst,
   input  pps_src_e i_pps_src,
   input  logic     i_pps_gpsdo,
   input  logic     i_pps_ext,
   output logic     o_pps
);

   localparam int CNT_W = $clog2(PPS_PERIOD);

   logic [CNT_W-1:0] period_cnt;
   logic             int_pps;
   logic [1:0]       gpsdo_del;
   logic [1:0]       ext_del;
   logic [1:0]       int_del;

   // one-cycle pulse every PPS_PERIOD cycles
   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         period_cnt <= '0;
         int_pps    <= 1'b0;
      end else if (period_cnt == CNT_W'(PPS_PERIOD - 1)) begin
         period_cnt <= '0;
         int_pps    <= 1'b1;
      end else begin
         period_cnt <= period_cnt + 1'b1;
         int_pps    <= 1'b0;
      end
   end

   // two flops on every source
   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         gpsdo_del <= '0;
         ext_del   <= '0;
         int_del   <= '0;
      end else begin
         gpsdo_del <= {gpsdo_del[0], i_pps_gpsdo};
         ext_del   <= {ext_del[0], i_pps_ext};
         int_del   <= {int_del[0], int_pps};
      end
   end

   always_comb begin
      case (i_pps_src)
         PPS_GPSDO:    o_pps = gpsdo_del[1];
         PPS_EXT:      o_pps = ext_del[1];
         PPS_INTERNAL: o_pps = int_del[1];
         default:      o_pps = 1'b0;
      endcase
   end

endmodule

// ==== source/ctrl_core.sv ====
// control core top: control demux, local processor, settings, response merge and PPS select
`timescale 1ns/1ns

module ctrl_core
   import core_pkg::*;
#(
   parameter int PPS_PERIOD = 100_000_000
) (
   input  logic              bus_clk,
   input  logic              bus_rst,
   input  logic [DATA_W-1:0] i_ctrl_tdata,
   input  logic              i_ctrl_tlast,
   input  logic              i_ctrl_tvalid,
   output logic              o_ctrl_tready,
   output logic [DATA_W-1:0] o_resp_tdata,
   output logic              o_resp_tlast,
   output logic              o_resp_tvalid,
   input  logic              i_resp_tready,
   output logic [DATA_W-1:0] o_r0_ctrl_tdata,
   output logic              o_r0_ctrl_tlast,
   output logic              o_r0_ctrl_tvalid,
   input  logic              i_r0_ctrl_tready,
   input  logic [DATA_W-1:0] i_r0_resp_tdata,
   input  logic              i_r0_resp_tlast,
   input  logic              i_r0_resp_tvalid,
   output logic              o_r0_resp_tready,
   input  logic              i_pps_int,
   input  logic              i_pps_ext,
   output logic              o_pps,
   input  logic [1:0]        i_lock_signals,
   input  logic [31:0]       i_rb_misc,
   output logic [31:0]       o_misc_outs
);

   // local processor streams
   logic [DATA_W-1:0] l0_ctrl_tdata;
   logic              l0_ctrl_tlast;
   logic              l0_ctrl_tvalid;
   logic              l0_ctrl_tready;
   logic [DATA_W-1:0] l0_resp_tdata;
   logic              l0_resp_tlast;
   logic              l0_resp_tvalid;
   logic              l0_resp_tready;

   // settings bus and readback
   logic              set_stb;
   logic [7:0]        set_addr;
   logic [31:0]       set_data;
   logic [DATA_W-1:0] rb_data;
   pps_src_e          pps_src;

   ////////////////////////////////////////////////////////////
   // control routing
   ////////////////////////////////////////////////////////////
   ctrl_demux u_ctrl_demux (
      .i_bus_clk      (bus_clk),
      .i_bus_rst      (bus_rst),
      .i_tdata        (i_ctrl_tdata),
      .i_tlast        (i_ctrl_tlast),
      .i_tvalid       (i_ctrl_tvalid),
      .o_tready       (o_ctrl_tready),
      .o_local_tdata  (l0_ctrl_tdata),
      .o_local_tlast  (l0_ctrl_tlast),
      .o_local_tvalid (l0_ctrl_tvalid),
      .i_local_tready (l0_ctrl_tready),
      .o_radio_tdata  (o_r0_ctrl_tdata),
      .o_radio_tlast  (o_r0_ctrl_tlast),
      .o_radio_tvalid (o_r0_ctrl_tvalid),
      .i_radio_tready (i_r0_ctrl_tready)
   );

   ctrl_proc u_ctrl_proc (
      .i_bus_clk     (bus_clk),
      .i_bus_rst     (bus_rst),
      .i_ctrl_tdata  (l0_ctrl_tdata),
      .i_ctrl_tlast  (l0_ctrl_tlast),
      .i_ctrl_tvalid (l0_ctrl_tvalid),
      .o_ctrl_tready (l0_ctrl_tready),
      .o_resp_tdata  (l0_resp_tdata),
      .o_resp_tlast  (l0_resp_tlast),
      .o_resp_tvalid (l0_resp_tvalid),
      .i_resp_tready (l0_resp_tready),
      .o_set_stb     (set_stb),
      .o_set_addr    (set_addr),
      .o_set_data    (set_data),
      .i_readback    (rb_data)
   );

   core_settings u_core_settings (
      .i_bus_clk      (bus_clk),
      .i_bus_rst      (bus_rst),
      .i_set_stb      (set_stb),
      .i_set_addr     (set_addr),
      .i_set_data     (set_data),
      .i_lock_signals (i_lock_signals),
      .i_rb_misc      (i_rb_misc),
      .o_readback     (rb_data),
      .o_misc_outs    (o_misc_outs),
      .o_pps_src      (pps_src)
   );

   // input a is the local processor, b the radio port
   resp_mux u_resp_mux (
      .i_bus_clk  (bus_clk),
      .i_bus_rst  (bus_rst),
      .i_a_tdata  (l0_resp_tdata),
      .i_a_tlast  (l0_resp_tlast),
      .i_a_tvalid (l0_resp_tvalid),
      .o_a_tready (l0_resp_tready),
      .i_b_tdata  (i_r0_resp_tdata),
      .i_b_tlast  (i_r0_resp_tlast),
      .i_b_tvalid (i_r0_resp_tvalid),
      .o_b_tready (o_r0_resp_tready),
      .o_tdata    (o_resp_tdata),
      .o_tlast    (o_resp_tlast),
      .o_tvalid   (o_resp_tvalid),
      .i_tready   (i_resp_tready)
   );

   ////////////////////////////////////////////////////////////
   // PPS
   ////////////////////////////////////////////////////////////
   pps_select #(
      .PPS_PERIOD (PPS_PERIOD)
   ) u_pps_select (
      .i_bus_clk   (bus_clk),
      .i_bus_rst   (bus_rst),
      .i_pps_src   (pps_src),
      .i_pps_gpsdo (i_pps_int),
      .i_pps_ext   (i_pps_ext),
      .o_pps       (o_pps)
   );

endmodule

// ==== sim/ctrl_core_tb.sv ====
// control core testbench: command stimulus, radio responder model, assertion checks and report
`timescale 1ns/1ns

module ctrl_core_tb;
   import core_pkg::*;

   localparam int          PPS_PERIOD  = 50;
   localparam int          PPS_WAIT    = 3 * PPS_PERIOD;
   localparam int          TOTAL_BEATS = 73;
   localparam int          TIMEOUT_CYC = TOTAL_BEATS * 20 + 4 * PPS_WAIT + 100;
   localparam logic [15:0] MARK        = 16'hbeef;

   logic        bus_clk;
   logic        bus_rst;
   logic [63:0] i_ctrl_tdata;
   logic        i_ctrl_tlast;
   logic        i_ctrl_tvalid;
   logic        o_ctrl_tready;
   logic [63:0] o_resp_tdata;
   logic        o_resp_tlast;
   logic        o_resp_tvalid;
   logic        i_resp_tready;
   logic [63:0] o_r0_ctrl_tdata;
   logic        o_r0_ctrl_tlast;
   logic        o_r0_ctrl_tvalid;
   logic        i_r0_ctrl_tready;
   logic [63:0] i_r0_resp_tdata;
   logic        i_r0_resp_tlast;
   logic        i_r0_resp_tvalid;
   logic        o_r0_resp_tready;
   logic        i_pps_int;
   logic        i_pps_ext;
   logic        o_pps;
   logic [1:0]  i_lock_signals;
   logic [31:0] i_rb_misc;
   logic [31:0] o_misc_outs;

   // expectation stores, written by the tests and consumed by the monitors
   logic [63:0] local_exp [0:127];
   logic [63:0] radio_exp [0:127];
   logic [64:0] rin_exp [0:127];
   int          local_rd, local_wr, radio_rd, radio_wr, rin_rd, rin_wr;
   logic [63:0] local_head, radio_head;
   logic [64:0] rin_head;

   // radio responder model
   logic [63:0] pend_hdr [0:31];
   logic [63:0] pend_data [0:31];
   int          pend_rd, pend_wr;
   logic [63:0] rhdr_q;
   logic        rin_mid, rsp_fire;

   logic        in_pkt, cur_radio, beat_radio, resp_beat, rin_beat;
   logic        bp_en, pps_chk, have_prev;
   pps_src_e    pps_mode;
   int          cyc, prev_cyc, pulses;
   int          seed, errors, err_start, tests_run, tests_failed;
   string       test_name;

   // reference model of the settings registers
   logic [31:0] misc_m;
   logic [2:0]  rbsel_m;
   logic [1:0]  pps_m;
   logic [15:0] seq;

   ctrl_core #(
      .PPS_PERIOD (PPS_PERIOD)
   ) DUT (
      .bus_clk          (bus_clk),
      .bus_rst          (bus_rst),
      .i_ctrl_tdata     (i_ctrl_tdata),
      .i_ctrl_tlast     (i_ctrl_tlast),
      .i_ctrl_tvalid    (i_ctrl_tvalid),
      .o_ctrl_tready    (o_ctrl_tready),
      .o_resp_tdata     (o_resp_tdata),
      .o_resp_tlast     (o_resp_tlast),
      .o_resp_tvalid    (o_resp_tvalid),
      .i_resp_tready    (i_resp_tready),
      .o_r0_ctrl_tdata  (o_r0_ctrl_tdata),
      .o_r0_ctrl_tlast  (o_r0_ctrl_tlast),
      .o_r0_ctrl_tvalid (o_r0_ctrl_tvalid),
      .i_r0_ctrl_tready (i_r0_ctrl_tready),
      .i_r0_resp_tdata  (i_r0_resp_tdata),
      .i_r0_resp_tlast  (i_r0_resp_tlast),
      .i_r0_resp_tvalid (i_r0_resp_tvalid),
      .o_r0_resp_tready (o_r0_resp_tready),
      .i_pps_int        (i_pps_int),
      .i_pps_ext        (i_pps_ext),
      .o_pps            (o_pps),
      .i_lock_signals   (i_lock_signals),
      .i_rb_misc        (i_rb_misc),
      .o_misc_outs      (o_misc_outs)
   );

   initial begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;
   end

   initial begin
      repeat (TIMEOUT_CYC) @(posedge bus_clk);
      $display("watchdog: the run did not finish in time, test %s stalled", test_name);
      $display("** FAIL **");
      $finish;
   end

   assign local_head = local_exp[local_rd];
   assign radio_head = radio_exp[radio_rd];
   assign rin_head   = rin_exp[rin_rd];
   assign resp_beat  = o_resp_tvalid && i_resp_tready;
   assign rin_beat   = o_r0_ctrl_tvalid && i_r0_ctrl_tready;
   assign beat_radio = in_pkt ? cur_radio : (o_resp_tdata[63:48] == MARK);

   ////////////////////////////////////////////////////////////
   // monitors
   ////////////////////////////////////////////////////////////
   always @(posedge bus_clk) begin
      cyc <= cyc + 1;
      if (!bus_rst && resp_beat) begin
         if (!in_pkt) begin
            cur_radio <= beat_radio;
         end
         if (beat_radio) begin
            radio_rd <= radio_rd + 1;
         end else begin
            local_rd <= local_rd + 1;
         end
         in_pkt <= !o_resp_tlast;
      end
      if (!bus_rst && rin_beat) begin
         rin_rd <= rin_rd + 1;
      end
   end

   // internal PPS pulse spacing
   always @(posedge bus_clk) begin
      if (!pps_chk) begin
         have_prev <= 1'b0;
         pulses    <= 0;
      end else if (o_pps) begin
         have_prev <= 1'b1;
         prev_cyc  <= cyc;
         pulses    <= pulses + 1;
      end
   end

   // radio loopback, header with marker and swapped SIDs, last beat as data
   always @(posedge bus_clk) begin
      rsp_fire <= i_r0_resp_tvalid && o_r0_resp_tready;
      if (!bus_rst && rin_beat) begin
         rin_mid <= !o_r0_ctrl_tlast;
         if (!rin_mid) begin
            rhdr_q <= o_r0_ctrl_tdata;
         end
         if (o_r0_ctrl_tlast) begin
            pend_hdr[pend_wr]  <= rin_mid ? {MARK, rhdr_q[47:16], rhdr_q[7:0], rhdr_q[15:8]} :
                                  {MARK, o_r0_ctrl_tdata[47:16], o_r0_ctrl_tdata[7:0],
                                   o_r0_ctrl_tdata[15:8]};
            pend_data[pend_wr] <= o_r0_ctrl_tdata;
            pend_wr            <= pend_wr + 1;
         end
      end
   end

   always @(negedge bus_clk) begin
      if (rsp_fire) begin
         if (i_r0_resp_tlast) begin
            i_r0_resp_tvalid = 1'b0;
            pend_rd          = pend_rd + 1;
         end else begin
            i_r0_resp_tdata = pend_data[pend_rd];
            i_r0_resp_tlast = 1'b1;
         end
      end
      if (!i_r0_resp_tvalid && pend_rd != pend_wr) begin
         i_r0_resp_tdata  = pend_hdr[pend_rd];
         i_r0_resp_tlast  = 1'b0;
         i_r0_resp_tvalid = 1'b1;
      end
      i_resp_tready = bp_en ? 1'($random(seed)) : 1'b1;
      i_pps_int     = 1'($random(seed));
      i_pps_ext     = 1'($random(seed));
   end

   ////////////////////////////////////////////////////////////
   // assertions
   ////////////////////////////////////////////////////////////
   a_resp_avail: assert property (@(posedge bus_clk) disable iff (bus_rst)
      resp_beat |-> (beat_radio ? (radio_rd != radio_wr) : (local_rd != local_wr)))
      else begin
         errors = errors + 1;
         $display("ERROR %s: response beat arrived with no response expected", test_name);
      end

   a_resp_data: assert property (@(posedge bus_clk) disable iff (bus_rst)
      resp_beat |-> o_resp_tdata == (beat_radio ? radio_head : local_head))
      else begin
         errors = errors + 1;
         $display("ERROR %s: response word expected %h actual %h", test_name,
                  $sampled(beat_radio ? radio_head : local_head), $sampled(o_resp_tdata));
      end

   a_resp_last: assert property (@(posedge bus_clk) disable iff (bus_rst)
      resp_beat |-> o_resp_tlast == in_pkt)
      else begin
         errors = errors + 1;
         $display("ERROR %s: response tlast expected %b actual %b", test_name,
                  $sampled(in_pkt), $sampled(o_resp_tlast));
      end

   a_resp_stable: assert property (@(posedge bus_clk) disable iff (bus_rst)
      o_resp_tvalid && !i_resp_tready |=>
         o_resp_tvalid && $stable(o_resp_tdata) && $stable(o_resp_tlast))
      else begin
         errors = errors + 1;
         $display("ERROR %s: response changed while tready was low", test_name);
      end

   a_radio_port: assert property (@(posedge bus_clk) disable iff (bus_rst)
      rin_beat |-> rin_rd != rin_wr && {o_r0_ctrl_tlast, o_r0_ctrl_tdata} == rin_head)
      else begin
         errors = errors + 1;
         $display("ERROR %s: radio port beat expected %h actual %h", test_name,
                  $sampled(rin_head), $sampled({o_r0_ctrl_tlast, o_r0_ctrl_tdata}));
      end

   a_pps_gpsdo: assert property (@(posedge bus_clk) disable iff (bus_rst)
      pps_chk && pps_mode == PPS_GPSDO |-> o_pps == $past(i_pps_int, 2))
      else begin
         errors = errors + 1;
         $display("ERROR %s: o_pps expected %b actual %b", test_name,
                  $past(i_pps_int, 2), $sampled(o_pps));
      end

   a_pps_ext: assert property (@(posedge bus_clk) disable iff (bus_rst)
      pps_chk && pps_mode == PPS_EXT |-> o_pps == $past(i_pps_ext, 2))
      else begin
         errors = errors + 1;
         $display("ERROR %s: o_pps expected %b actual %b", test_name,
                  $past(i_pps_ext, 2), $sampled(o_pps));
      end

   a_pps_int: assert property (@(posedge bus_clk) disable iff (bus_rst)
      pps_chk && pps_mode == PPS_INTERNAL && o_pps && have_prev |->
         (cyc - prev_cyc) == PPS_PERIOD)
      else begin
         errors = errors + 1;
         $display("ERROR %s: PPS spacing expected %0d actual %0d", test_name,
                  PPS_PERIOD, $sampled(cyc - prev_cyc));
      end

   a_pps_off: assert property (@(posedge bus_clk) disable iff (bus_rst)
      pps_chk && pps_mode == PPS_OFF |-> !o_pps)
      else begin
         errors = errors + 1;
         $display("ERROR %s: o_pps expected 0 actual 1", test_name);
      end

   ////////////////////////////////////////////////////////////
   // stimulus tasks
   ////////////////////////////////////////////////////////////
   // tready is looked at on the rising edge, where the beat transfers
   task automatic send_beat(input logic [63:0] d, input logic l);
      i_ctrl_tdata  = d;
      i_ctrl_tlast  = l;
      i_ctrl_tvalid = 1'b1;
      @(posedge bus_clk);
      while (!o_ctrl_tready) @(posedge bus_clk);
      @(negedge bus_clk);
      i_ctrl_tvalid = 1'b0;
   endtask

   function automatic logic [63:0] model_readback();
      case (rbsel_m)
         3'd0:    return {32'hace0ba5e, 16'h000e, 16'h0000};
         3'd1:    return {32'h0, i_rb_misc};
         3'd2:    return {62'h0, i_lock_signals};
         3'd3:    return {30'h0, pps_m, misc_m};
         default: return 64'h0;
      endcase
   endfunction

   task automatic local_cmd(input logic [7:0] addr, input logic [31:0] data, input logic extra);
      logic [63:0] hdr;
      hdr = {16'h0, 16'h1234, seq, 8'h21, 8'h40 | 8'(seq[3:0])};
      seq = seq + 1;
      case (addr)
         SR_CORE_MISC:     misc_m  = data;
         SR_CORE_READBACK: rbsel_m = data[2:0];
         SR_CORE_SYNC:     pps_m   = data[1:0];
         default:          ;
      endcase
      local_exp[local_wr]     = {hdr[63:16], hdr[7:0], hdr[15:8]};
      local_exp[local_wr + 1] = model_readback();
      local_wr                = local_wr + 2;
      send_beat(hdr, 1'b0);
      send_beat({24'h0, addr, data}, !extra);
      if (extra) begin
         send_beat({24'h0, SR_CORE_MISC, ~data}, 1'b1);
      end
   endtask

   task automatic radio_pkt(input int nbeats);
      logic [63:0] hdr;
      logic [63:0] d;
      hdr = {16'h0, 16'h5678, seq, 8'h31, 8'h10 | 8'(seq[3:0])};
      seq = seq + 1;
      d   = hdr;
      for (int i = 0; i < nbeats; i++) begin
         if (i > 0) begin
            d = {seq, 16'(i), 32'hc0ffee00 + i};
         end
         rin_exp[rin_wr] = {(i == nbeats - 1), d};
         rin_wr          = rin_wr + 1;
      end
      radio_exp[radio_wr]     = {MARK, hdr[47:16], hdr[7:0], hdr[15:8]};
      radio_exp[radio_wr + 1] = d;
      radio_wr                = radio_wr + 2;
      for (int i = 0; i < nbeats; i++) begin
         send_beat(rin_exp[rin_wr - nbeats + i][63:0], rin_exp[rin_wr - nbeats + i][64]);
      end
   endtask

   task automatic wait_drained();
      while (local_rd != local_wr || radio_rd != radio_wr || rin_rd != rin_wr) begin
         @(negedge bus_clk);
      end
      repeat (4) @(negedge bus_clk);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_start = errors;
      tests_run = tests_run + 1;
   endtask

   task automatic end_test();
      wait_drained();
      if (errors == err_start) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %s: %0d errors", test_name, errors - err_start);
      end
   endtask

   task automatic check_misc();
      assert (o_misc_outs == misc_m)
      else begin
         errors = errors + 1;
         $display("ERROR %s: o_misc_outs expected %h actual %h", test_name, misc_m, o_misc_outs);
      end
   endtask

   task automatic pps_case(input pps_src_e src);
      pps_chk = 1'b0;
      local_cmd(SR_CORE_SYNC, 32'(src), 1'b0);
      wait_drained();
      pps_mode = src;
      pps_chk  = 1'b1;
      repeat (PPS_WAIT) @(negedge bus_clk);
      if (src == PPS_INTERNAL && pulses < 2) begin
         errors = errors + 1;
         $display("ERROR %s: internal PPS gave fewer than two pulses", test_name);
      end
      pps_chk = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      seed = 17731;
      {errors, tests_run, tests_failed, cyc, prev_cyc, pulses} = '0;
      {local_rd, local_wr, radio_rd, radio_wr, rin_rd, rin_wr, pend_rd, pend_wr} = '0;
      {in_pkt, cur_radio, rin_mid, rsp_fire, have_prev, bp_en, pps_chk} = '0;
      pps_mode         = PPS_GPSDO;
      test_name        = "reset";
      bus_rst          = 1'b1;
      i_ctrl_tdata     = '0;
      i_ctrl_tlast     = 1'b0;
      i_ctrl_tvalid    = 1'b0;
      i_resp_tready    = 1'b1;
      i_r0_ctrl_tready = 1'b1;
      i_r0_resp_tdata  = '0;
      i_r0_resp_tlast  = 1'b0;
      i_r0_resp_tvalid = 1'b0;
      i_pps_int        = 1'b0;
      i_pps_ext        = 1'b0;
      i_lock_signals   = 2'b10;
      i_rb_misc        = 32'hdeadc0de;
      misc_m           = '0;
      rbsel_m          = '0;
      pps_m            = '0;
      seq              = 16'h0100;
      repeat (5) @(posedge bus_clk);
      @(negedge bus_clk);
      bus_rst = 1'b0;
      repeat (2) @(negedge bus_clk);

      begin_test("compat_readback");
      local_cmd(SR_CORE_READBACK, 32'd0, 1'b0);
      end_test();

      begin_test("misc_write");
      local_cmd(SR_CORE_MISC, 32'ha5a55a5a, 1'b0);
      wait_drained();
      check_misc();
      local_cmd(SR_CORE_READBACK, 32'd3, 1'b0);
      local_cmd(SR_CORE_MISC, 32'h00001111, 1'b1);
      wait_drained();
      check_misc();
      end_test();

      begin_test("radio_merge");
      bp_en = 1'b1;
      radio_pkt(2);
      local_cmd(SR_CORE_READBACK, 32'd0, 1'b0);
      radio_pkt(3);
      local_cmd(SR_CORE_READBACK, 32'd3, 1'b0);
      radio_pkt(2);
      end_test();

      begin_test("unknown_sid");
      bp_en = 1'b0;
      send_beat({16'h0, 16'h9999, seq, 8'h21, 8'h7a}, 1'b0);
      send_beat(64'h0000_0010_ffff_ffff, 1'b0);
      send_beat(64'h0, 1'b1);
      local_cmd(SR_CORE_READBACK, 32'd0, 1'b0);
      end_test();

      begin_test("misc_in_lock");
      bp_en = 1'b1;
      local_cmd(SR_CORE_READBACK, 32'd1, 1'b0);
      local_cmd(SR_CORE_READBACK, 32'd2, 1'b0);
      end_test();

      begin_test("pps_select");
      bp_en = 1'b0;
      local_cmd(SR_CORE_READBACK, 32'd3, 1'b0);
      pps_case(PPS_GPSDO);
      pps_case(PPS_EXT);
      pps_case(PPS_INTERNAL);
      pps_case(PPS_OFF);
      end_test();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
common/core_pkg.sv
source/ctrl_demux.sv
source/resp_mux.sv
ctrl_proc/ctrl_proc.sv
ctrl_proc/core_settings.sv
source/pps_select.sv
source/ctrl_core.sv
sim/ctrl_core_tb.sv
